/* proc.f */
verilog/procPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/memArbiter.sv
verilog/mainMemory.sv
verilog/proc.sv
tests/procTb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - verilog/procPkg.sv
  - verilog/fetchStage.sv
  - verilog/decodeStage.sv
  - verilog/executeStage.sv
  - verilog/memoryStage.sv
  - verilog/memArbiter.sv
  - verilog/mainMemory.sv
  - verilog/proc.sv
  - target: test
    files:
      - tests/procTb.sv

/* tests/procTb.sv */
// testbench for the pipelined core
// LFSR program generator, instruction-set reference model
// boot load, run and retire compare processes with reporting
module procTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int memWords = 256;
	localparam int memLatency = 2;
	localparam int numPrograms = 12;
	localparam int runLimit = 5000;
	localparam int outNone = 0;
	localparam int outHalt = 1;
	localparam int outErr = 2;

	logic clk;
	logic rstN;
	logic loadEn;
	logic [procPkg::dataWidth-1:0] loadAddr;
	logic [procPkg::dataWidth-1:0] loadData;
	logic retireValid;
	logic [procPkg::regAddrWidth-1:0] retireReg;
	logic [procPkg::dataWidth-1:0] retireData;
	logic halted;
	logic err;

	logic [15:0] image [0:memWords-1];
	logic [15:0] lfsrState;
	int expReg [$];
	logic [15:0] expData [$];
	int expIdx;
	int expOutcome;
	int errCount;
	int genPc;
	int genLast;
	int prevRd;
	int progsRun;
	bit checking;
	bit haltSeen;
	bit errSeen;
	bit aborted;
	bit timedOut;

	proc #(.memWords(memWords), .memLatency(memLatency)) proc_i (
		.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
		.halted(halted), .err(err)
	);

	always #10 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsrBit());
		end
		return v;
	endfunction

	// r7 is reserved as the data base pointer
	function automatic int destReg();
		int v;
		v = randBits(3);
		return (v == 7) ? 0 : v;
	endfunction

	function automatic logic [15:0] fillWord(input int addr);
		logic [7:0] a;
		a = 8'(addr);
		return {a ^ 8'hC3, ~a};
	endfunction

	function automatic logic [15:0] encR(input int fn, input int rd, input int rs, input int rt);
		return {procPkg::opAlu, 3'(rd), 3'(rs), 3'(rt), 3'(fn)};
	endfunction

	function automatic logic [15:0] encI(input procPkg::opcodeT op, input int rd, input int rs,
		input int imm);
		return {op, 3'(rd), 3'(rs), 6'(imm)};
	endfunction

	task automatic putWord(input logic [15:0] w);
		image[genPc] = w;
		genPc++;
	endtask

	task automatic emitAluOp();
		int rd;
		int rs;
		int rt;
		int fn;
		rs = randBits(1) ? prevRd : randBits(3);
		rt = randBits(1) ? prevRd : randBits(3);
		rd = destReg();
		if (randBits(2) == 0) begin
			putWord(encI(procPkg::opAddi, rd, rs, randBits(6)));
		end else begin
			fn = randBits(3);
			if (fn > 5) begin
				fn = fn - 6;
			end
			putWord(encR(fn, rd, rs, rt));
		end
		prevRd = rd;
	endtask

	// store, load back and use the loaded value at once
	task automatic emitMemGroup();
		int src;
		int rd;
		int imm;
		imm = randBits(6);
		src = randBits(3);
		rd = destReg();
		putWord(encI(procPkg::opStore, src, 7, imm));
		putWord(encI(procPkg::opLoad, rd, 7, randBits(1) ? imm : randBits(6)));
		putWord(encR(procPkg::fnAdd, destReg(), rd, prevRd));
		prevRd = rd;
	endtask

	// forward branches only, never past the last instruction
	task automatic emitBranch();
		int r;
		int maxImm;
		int imm;
		if (randBits(1)) begin
			r = destReg();
			putWord(encR(procPkg::fnXor, r, r, r));
		end else begin
			r = randBits(3);
		end
		maxImm = genLast - genPc - 1;
		if (maxImm > 31) begin
			maxImm = 31;
		end
		imm = randBits(3);
		if (imm > maxImm) begin
			imm = maxImm;
		end
		putWord(encI(procPkg::opBeqz, r, 0, imm));
	endtask

	// kind 0 ALU, 1 memory, 2 branch, 3 ends in an illegal opcode
	task automatic genProgram(input int kind);
		for (int a = 0; a < memWords; a++) begin
			image[a] = fillWord(a);
		end
		genPc = 0;
		prevRd = 0;
		// r7 = 24 doubled three times, data lands in 160..223
		putWord(encI(procPkg::opAddi, 7, 7, 24));
		repeat (3) putWord(encR(procPkg::fnAdd, 7, 7, 7));
		genLast = genPc + 16 + randBits(4);
		while (genPc < genLast) begin
			if (kind == 1 && genPc + 3 <= genLast && randBits(1)) begin
				emitMemGroup();
			end else if (kind == 2 && genPc + 2 <= genLast && randBits(1)) begin
				emitBranch();
			end else begin
				emitAluOp();
			end
		end
		if (kind == 3) begin
			putWord({4'(8 + randBits(3)), 12'(randBits(12))});
			putWord(encI(procPkg::opAddi, 1, 1, 1));
		end
		putWord(encI(procPkg::opHalt, 0, 0, 0));
	endtask

	function automatic void noteRetire(input int r, input logic [15:0] v);
		expReg.push_back(r);
		expData.push_back(v);
	endfunction

	// instruction-set model, fills the expected retire list
	function automatic int runReference();
		logic [15:0] mem [0:memWords-1];
		logic [15:0] regs [0:7];
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm;
		logic [15:0] res;
		logic [15:0] addr;
		logic [2:0] rd;
		int pc;
		expReg.delete();
		expData.delete();
		for (int i = 0; i < memWords; i++) begin
			mem[i] = image[i];
		end
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		for (int steps = 0; steps < 4000; steps++) begin
			w = mem[pc % memWords];
			rd = w[11:9];
			a = regs[w[8:6]];
			b = regs[w[5:3]];
			imm = {{10{w[5]}}, w[5:0]};
			addr = a + imm;
			pc++;
			case (w[15:12])
				procPkg::opAlu: begin
					case (w[2:0])
						procPkg::fnSub: res = a - b;
						procPkg::fnAnd: res = a & b;
						procPkg::fnOr:  res = a | b;
						procPkg::fnXor: res = a ^ b;
						procPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
						default:        res = a + b;
					endcase
					regs[rd] = res;
					noteRetire(rd, res);
				end
				procPkg::opAddi: begin
					regs[rd] = addr;
					noteRetire(rd, addr);
				end
				procPkg::opLoad: begin
					regs[rd] = mem[addr % memWords];
					noteRetire(rd, regs[rd]);
				end
				procPkg::opStore: mem[addr % memWords] = regs[rd];
				procPkg::opBeqz: begin
					if (regs[rd] == 16'd0) begin
						pc = pc + $signed(imm);
					end
				end
				procPkg::opNop: begin
				end
				procPkg::opHalt: return outHalt;
				default: return outErr;
			endcase
		end
		return outNone;
	endfunction

	task automatic expectEqual(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
			errCount++;
		end
	endtask

	// reset with the core held idle, then write the whole memory image
	task automatic bootProgram();
		@(negedge clk);
		rstN = 1'b0;
		loadEn = 1'b1;
		repeat (5) @(negedge clk);
		rstN = 1'b1;
		for (int a = 0; a < memWords; a++) begin
			loadAddr = 16'(a);
			loadData = image[a];
			@(negedge clk);
		end
		expIdx = 0;
		loadEn = 1'b0;
		checking = 1'b1;
	endtask

	task automatic waitForEnd(output bit late);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && err !== 1'b1 && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
		end
		late = (halted !== 1'b1 && err !== 1'b1);
	endtask

	task automatic checkEnd(input int prog);
		if (expIdx != expReg.size()) begin
			$display("program %0d retired %0d of %0d expected instructions",
				prog, expIdx, expReg.size());
			errCount++;
		end
		expectEqual("halted", 16'(expOutcome == outHalt), 16'(halted));
		expectEqual("err", 16'(expOutcome == outErr), 16'(err));
	endtask

	// retire compare and sticky status checks
	always @(negedge clk) begin
		if (rstN === 1'b1 && loadEn === 1'b1) begin
			expectEqual("retireValid", 16'd0, 16'(retireValid));
			expectEqual("halted", 16'd0, 16'(halted));
			expectEqual("err", 16'd0, 16'(err));
		end
		if (checking) begin
			if (retireValid === 1'b1) begin
				if (expIdx < expReg.size()) begin
					expectEqual("retireReg", 16'(expReg[expIdx]), 16'(retireReg));
					expectEqual("retireData", expData[expIdx], retireData);
					expIdx++;
				end else begin
					$display("t=%0t unexpected retire of r%0d after the program ended",
						$time, retireReg);
					errCount++;
				end
			end else if (retireValid !== 1'b0) begin
				$display("t=%0t retireValid is unknown", $time);
				errCount++;
			end
			if (haltSeen) begin
				expectEqual("halted", 16'd1, 16'(halted));
			end
			if (errSeen) begin
				expectEqual("err", 16'd1, 16'(err));
			end
			if (halted === 1'b1) begin
				haltSeen = 1'b1;
			end
			if (err === 1'b1) begin
				errSeen = 1'b1;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		loadEn = 1'b1;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 16'd93;
		errCount = 0;
		expIdx = 0;
		progsRun = 0;
		checking = 1'b0;
		haltSeen = 1'b0;
		errSeen = 1'b0;
		aborted = 1'b0;
		for (int prog = 0; prog < numPrograms && !aborted; prog++) begin
			checking = 1'b0;
			haltSeen = 1'b0;
			errSeen = 1'b0;
			genProgram(prog % 4);
			expOutcome = runReference();
			bootProgram();
			waitForEnd(timedOut);
			progsRun++;
			if (timedOut) begin
				$display("program %0d never reached halt or err", prog);
				errCount++;
				aborted = 1'b1;
			end else begin
				// quiet window, nothing may retire behind halt or err
				repeat (30) @(negedge clk);
				checkEnd(prog);
			end
		end
		$display("errors: %0d over %0d programs", errCount, progsRun);
		if (errCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/proc.sv */
// top level of the pipelined core
// fetch, decode, execute and memory stages around one shared memory
module proc #(
	parameter int memWords = 256,
	parameter int memLatency = 2
) (
	input  logic clk,
	input  logic rstN,
	input  logic loadEn,
	input  logic [procPkg::dataWidth-1:0] loadAddr,
	input  logic [procPkg::dataWidth-1:0] loadData,
	output logic retireValid,
	output logic [procPkg::regAddrWidth-1:0] retireReg,
	output logic [procPkg::dataWidth-1:0] retireData,
	output logic halted,
	output logic err
);
	// memory port handshakes
	logic iReq, iGrant, iDone;
	logic dReq, dWrite, dGrant, dDone;
	logic [procPkg::dataWidth-1:0] iAddr, dAddr, dWdata;
	logic memReq, memWrite, memAck;
	logic [procPkg::dataWidth-1:0] memAddr, memWdata, memRdata;

	// stalls, flush and redirect
	logic dStall, hazStall, brTaken, stopFetch;
	logic [procPkg::dataWidth-1:0] brTarget;

	// pipeline registers
	logic ifValid;
	procPkg::instrT ifInstr;
	logic [procPkg::dataWidth-1:0] ifPc;
	logic idValid, idWen;
	procPkg::opcodeT idOp;
	procPkg::functT idFunct;
	logic [procPkg::dataWidth-1:0] idA, idB, idImm;
	logic [procPkg::regAddrWidth-1:0] idDest;
	logic exValid, exWen;
	procPkg::opcodeT exOp;
	logic [procPkg::dataWidth-1:0] exResult, exStoreData;
	logic [procPkg::regAddrWidth-1:0] exDest;
	logic wbWen;
	logic [procPkg::regAddrWidth-1:0] wbReg;
	logic [procPkg::dataWidth-1:0] wbData;

	fetchStage fetch (
		.clk(clk), .rstN(rstN), .loadEn(loadEn), .hazStall(hazStall), .dStall(dStall),
		.brTaken(brTaken), .brTarget(brTarget), .stopFetch(stopFetch),
		.iGrant(iGrant), .iDone(iDone), .memRdata(memRdata),
		.iReq(iReq), .iAddr(iAddr), .iStall(), .ifValid(ifValid),
		.ifInstr(ifInstr), .ifPc(ifPc)
	);

	// EX and MEM destinations feed the hazard check
	decodeStage decode (
		.clk(clk), .rstN(rstN), .ifValid(ifValid), .ifInstr(ifInstr), .ifPc(ifPc),
		.dStall(dStall), .exDest(idDest), .exWen(idWen), .memDest(exDest), .memWen(exWen),
		.wbWen(wbWen), .wbReg(wbReg), .wbData(wbData),
		.hazStall(hazStall), .brTaken(brTaken), .brTarget(brTarget),
		.idValid(idValid), .idOp(idOp), .idFunct(idFunct), .idA(idA), .idB(idB),
		.idImm(idImm), .idDest(idDest), .idWen(idWen)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN), .dStall(dStall), .idValid(idValid), .idOp(idOp),
		.idFunct(idFunct), .idA(idA), .idB(idB), .idImm(idImm), .idDest(idDest),
		.idWen(idWen), .exValid(exValid), .exOp(exOp), .exResult(exResult),
		.exStoreData(exStoreData), .exDest(exDest), .exWen(exWen)
	);

	memoryStage memory (
		.clk(clk), .rstN(rstN), .exValid(exValid), .exOp(exOp), .exResult(exResult),
		.exStoreData(exStoreData), .exDest(exDest), .exWen(exWen),
		.dGrant(dGrant), .dDone(dDone), .memRdata(memRdata),
		.dReq(dReq), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata), .dStall(dStall),
		.wbWen(wbWen), .wbReg(wbReg), .wbData(wbData),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
		.halted(halted), .err(err), .stopFetch(stopFetch)
	);

	memArbiter #(.memWords(memWords)) arbiter (
		.clk(clk), .rstN(rstN), .iReq(iReq), .iAddr(iAddr),
		.dReq(dReq), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata), .memAck(memAck),
		.iGrant(iGrant), .iDone(iDone), .dGrant(dGrant), .dDone(dDone),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata)
	);

	mainMemory #(.memWords(memWords), .memLatency(memLatency)) ram (
		.clk(clk), .rstN(rstN), .memReq(memReq), .memWrite(memWrite),
		.memAddr(memAddr), .memWdata(memWdata),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.memAck(memAck), .memRdata(memRdata)
	);

endmodule

/* verilog/mainMemory.sv */
// word RAM with fixed access latency
// boot load write port takes priority
module mainMemory #(
	parameter int memWords = 256,
	parameter int memLatency = 2
) (
	input  logic clk,
	input  logic rstN,
	input  logic memReq,
	input  logic memWrite,
	input  logic [procPkg::dataWidth-1:0] memAddr,
	input  logic [procPkg::dataWidth-1:0] memWdata,
	input  logic loadEn,
	input  logic [procPkg::dataWidth-1:0] loadAddr,
	input  logic [procPkg::dataWidth-1:0] loadData,
	output logic memAck,
	output logic [procPkg::dataWidth-1:0] memRdata
);
	localparam int addrBits = $clog2(memWords);
	localparam int cntBits = (memLatency > 1) ? $clog2(memLatency) : 1;

	logic [procPkg::dataWidth-1:0] ram [0:memWords-1];
	logic pending;
	logic [cntBits-1:0] count;
	logic [addrBits-1:0] addrQ;
	logic writeQ;
	logic [procPkg::dataWidth-1:0] wdataQ;

	assign memAck = pending && count == '0;
	// read data is valid in the ack cycle
	assign memRdata = ram[addrQ];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
			count <= '0;
		end else if (memReq) begin
			pending <= 1'b1;
			count <= cntBits'(memLatency - 1);
		end else if (memAck) begin
			pending <= 1'b0;
		end else if (pending) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (memReq) begin
			addrQ <= memAddr[addrBits-1:0];
			writeQ <= memWrite;
			wdataQ <= memWdata;
		end
		if (loadEn) begin
			ram[loadAddr[addrBits-1:0]] <= loadData;
		end else if (memAck && writeQ) begin
			ram[addrQ] <= wdataQ;
		end
	end

endmodule

/* verilog/memArbiter.sv */
// single memory port shared by fetch and data access
// fixed priority to data with one access in flight
module memArbiter #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic rstN,
	input  logic iReq,
	input  logic [procPkg::dataWidth-1:0] iAddr,
	input  logic dReq,
	input  logic dWrite,
	input  logic [procPkg::dataWidth-1:0] dAddr,
	input  logic [procPkg::dataWidth-1:0] dWdata,
	input  logic memAck,
	output logic iGrant,
	output logic iDone,
	output logic dGrant,
	output logic dDone,
	output logic memReq,
	output logic memWrite,
	output logic [procPkg::dataWidth-1:0] memAddr,
	output logic [procPkg::dataWidth-1:0] memWdata
);
	logic busy;
	logic ownerData;

	assign dGrant = !busy && dReq;
	assign iGrant = !busy && iReq && !dReq;
	assign memReq = dGrant || iGrant;
	assign memWrite = dGrant && dWrite;
	assign memAddr = dGrant ? dAddr : iAddr;
	assign memWdata = dWdata;

	// ack goes back to whoever holds the port
	assign dDone = busy && ownerData && memAck;
	assign iDone = busy && !ownerData && memAck;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			ownerData <= 1'b0;
		end else if (memReq) begin
			busy <= 1'b1;
			ownerData <= dGrant;
		end else if (memAck) begin
			busy <= 1'b0;
		end
	end

	// the memory answers only an access in flight
	ackInFlight: assert property (@(posedge clk) disable iff (!rstN)
		memAck |-> busy);

	addrInRange: assert property (@(posedge clk) disable iff (!rstN)
		memReq |-> memAddr < memWords);

endmodule

/* verilog/memoryStage.sv */
// data memory request and write-back select
// MEM/WB register, retire outputs, halt and err
module memoryStage (
	input  logic clk,
	input  logic rstN,
	input  logic exValid,
	input  procPkg::opcodeT exOp,
	input  logic [procPkg::dataWidth-1:0] exResult,
	input  logic [procPkg::dataWidth-1:0] exStoreData,
	input  logic [procPkg::regAddrWidth-1:0] exDest,
	input  logic exWen,
	input  logic dGrant,
	input  logic dDone,
	input  logic [procPkg::dataWidth-1:0] memRdata,
	output logic dReq,
	output logic dWrite,
	output logic [procPkg::dataWidth-1:0] dAddr,
	output logic [procPkg::dataWidth-1:0] dWdata,
	output logic dStall,
	output logic wbWen,
	output logic [procPkg::regAddrWidth-1:0] wbReg,
	output logic [procPkg::dataWidth-1:0] wbData,
	output logic retireValid,
	output logic [procPkg::regAddrWidth-1:0] retireReg,
	output logic [procPkg::dataWidth-1:0] retireData,
	output logic halted,
	output logic err,
	output logic stopFetch
);
	logic live;
	logic legal;
	logic dGranted;

	// nothing behind a halt or an illegal opcode takes effect
	assign live = exValid && !halted && !err;
	assign legal = exOp inside {procPkg::opHalt, procPkg::opNop, procPkg::opAlu,
		procPkg::opAddi, procPkg::opLoad, procPkg::opStore, procPkg::opBeqz};

	assign dReq = live && (exOp == procPkg::opLoad || exOp == procPkg::opStore);
	assign dWrite = (exOp == procPkg::opStore);
	assign dAddr = exResult;
	assign dWdata = exStoreData;
	assign dStall = dReq && !dDone;
	assign stopFetch = halted || err;

	assign retireValid = wbWen;
	assign retireReg = wbReg;
	assign retireData = wbData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbWen <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
			dGranted <= 1'b0;
		end else begin
			// MEM/WB takes a bubble while the data access waits
			wbWen <= live && exWen && !dStall;
			if (dGrant) begin
				dGranted <= 1'b1;
			end else if (dDone) begin
				dGranted <= 1'b0;
			end
			if (live && exOp == procPkg::opHalt) begin
				halted <= 1'b1;
			end
			if (live && !legal) begin
				err <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!dStall) begin
			wbReg <= exDest;
			wbData <= (exOp == procPkg::opLoad) ? memRdata : exResult;
		end
	end

	dDoneGranted: assert property (@(posedge clk) disable iff (!rstN)
		dDone |-> dGranted);

	noRetireAfterErr: assert property (@(posedge clk) disable iff (!rstN)
		retireValid |-> !err);

endmodule

/* verilog/executeStage.sv */
// ALU with immediate operand select
// EX/MEM pipeline register
module executeStage (
	input  logic clk,
	input  logic rstN,
	input  logic dStall,
	input  logic idValid,
	input  procPkg::opcodeT idOp,
	input  procPkg::functT idFunct,
	input  logic [procPkg::dataWidth-1:0] idA,
	input  logic [procPkg::dataWidth-1:0] idB,
	input  logic [procPkg::dataWidth-1:0] idImm,
	input  logic [procPkg::regAddrWidth-1:0] idDest,
	input  logic idWen,
	output logic exValid,
	output procPkg::opcodeT exOp,
	output logic [procPkg::dataWidth-1:0] exResult,
	output logic [procPkg::dataWidth-1:0] exStoreData,
	output logic [procPkg::regAddrWidth-1:0] exDest,
	output logic exWen
);
	logic [procPkg::dataWidth-1:0] opB;
	logic [procPkg::dataWidth-1:0] aluOut;

	// everything but R-format adds the immediate, loads and stores included
	assign opB = (idOp == procPkg::opAlu) ? idB : idImm;

	always_comb begin
		aluOut = idA + opB;
		if (idOp == procPkg::opAlu) begin
			case (idFunct)
				procPkg::fnSub: aluOut = idA - opB;
				procPkg::fnAnd: aluOut = idA & opB;
				procPkg::fnOr:  aluOut = idA | opB;
				procPkg::fnXor: aluOut = idA ^ opB;
				procPkg::fnSlt: aluOut = {{(procPkg::dataWidth-1){1'b0}}, $signed(idA) < $signed(opB)};
				default:        aluOut = idA + opB;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
			exWen <= 1'b0;
		end else if (!dStall) begin
			exValid <= idValid;
			exWen <= idValid && idWen;
		end
	end

	always_ff @(posedge clk) begin
		if (!dStall) begin
			exOp <= idOp;
			exResult <= aluOut;
			exStoreData <= idB;
			exDest <= idDest;
		end
	end

endmodule

/* verilog/decodeStage.sv */
// register file with write-through
// decode control, hazard stall and beqz resolution
// ID/EX pipeline register
module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic ifValid,
	input  procPkg::instrT ifInstr,
	input  logic [procPkg::dataWidth-1:0] ifPc,
	input  logic dStall,
	input  logic [procPkg::regAddrWidth-1:0] exDest,
	input  logic exWen,
	input  logic [procPkg::regAddrWidth-1:0] memDest,
	input  logic memWen,
	input  logic wbWen,
	input  logic [procPkg::regAddrWidth-1:0] wbReg,
	input  logic [procPkg::dataWidth-1:0] wbData,
	output logic hazStall,
	output logic brTaken,
	output logic [procPkg::dataWidth-1:0] brTarget,
	output logic idValid,
	output procPkg::opcodeT idOp,
	output procPkg::functT idFunct,
	output logic [procPkg::dataWidth-1:0] idA,
	output logic [procPkg::dataWidth-1:0] idB,
	output logic [procPkg::dataWidth-1:0] idImm,
	output logic [procPkg::regAddrWidth-1:0] idDest,
	output logic idWen
);
	localparam int numRegs = 1 << procPkg::regAddrWidth;

	logic [procPkg::dataWidth-1:0] regs [0:numRegs-1];
	procPkg::opcodeT op;
	logic [procPkg::regAddrWidth-1:0] rdSel;
	logic [procPkg::regAddrWidth-1:0] rsSel;
	logic [procPkg::regAddrWidth-1:0] rtSel;
	logic [procPkg::dataWidth-1:0] rdVal;
	logic [procPkg::dataWidth-1:0] rsVal;
	logic [procPkg::dataWidth-1:0] rtVal;
	logic [procPkg::dataWidth-1:0] immExt;
	logic useRs;
	logic useRt;
	logic useRd;
	logic rdBusy;
	logic rsBusy;
	logic rtBusy;
	logic writesReg;

	assign op = ifInstr.rType.opcode;
	assign rdSel = ifInstr.rType.rd;
	assign rsSel = ifInstr.rType.rs;
	assign rtSel = ifInstr.rType.rt;
	assign immExt = {{(procPkg::dataWidth-6){ifInstr.iType.imm[5]}}, ifInstr.iType.imm};

	// write-back value bypasses the array in the same cycle
	assign rdVal = (wbWen && wbReg == rdSel) ? wbData : regs[rdSel];
	assign rsVal = (wbWen && wbReg == rsSel) ? wbData : regs[rsSel];
	assign rtVal = (wbWen && wbReg == rtSel) ? wbData : regs[rtSel];

	assign useRs = op inside {procPkg::opAlu, procPkg::opAddi, procPkg::opLoad, procPkg::opStore};
	assign useRt = (op == procPkg::opAlu);
	// store data and the beqz test both come from rd
	assign useRd = op inside {procPkg::opStore, procPkg::opBeqz};
	assign writesReg = op inside {procPkg::opAlu, procPkg::opAddi, procPkg::opLoad};

	assign rdBusy = (exWen && exDest == rdSel) || (memWen && memDest == rdSel);
	assign rsBusy = (exWen && exDest == rsSel) || (memWen && memDest == rsSel);
	assign rtBusy = (exWen && exDest == rtSel) || (memWen && memDest == rtSel);
	assign hazStall = ifValid && ((useRs && rsBusy) || (useRt && rtBusy) || (useRd && rdBusy));

	assign brTaken = ifValid && !hazStall && !dStall && op == procPkg::opBeqz && rdVal == '0;
	assign brTarget = ifPc + 1'b1 + immExt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWen) begin
			regs[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idWen <= 1'b0;
		end else if (!dStall) begin
			// a hazard sends a bubble down
			idValid <= ifValid && !hazStall;
			idWen <= ifValid && !hazStall && writesReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!dStall) begin
			idOp <= op;
			idFunct <= ifInstr.rType.funct;
			idA <= rsVal;
			idB <= (op == procPkg::opStore) ? rdVal : rtVal;
			idImm <= immExt;
			idDest <= rdSel;
		end
	end

	// a taken branch leaves a bubble in IF/ID
	branchFlushes: assert property (@(posedge clk) disable iff (!rstN)
		brTaken |=> !ifValid);

endmodule

/* verilog/fetchStage.sv */
// PC register and single-word instruction request
// IF/ID register with stall, bubble and branch flush
module fetchStage (
	input  logic clk,
	input  logic rstN,
	input  logic loadEn,
	input  logic hazStall,
	input  logic dStall,
	input  logic brTaken,
	input  logic [procPkg::dataWidth-1:0] brTarget,
	input  logic stopFetch,
	input  logic iGrant,
	input  logic iDone,
	input  logic [procPkg::dataWidth-1:0] memRdata,
	output logic iReq,
	output logic [procPkg::dataWidth-1:0] iAddr,
	output logic iStall,
	output logic ifValid,
	output procPkg::instrT ifInstr,
	output logic [procPkg::dataWidth-1:0] ifPc
);
	logic [procPkg::dataWidth-1:0] pc;
	logic [procPkg::dataWidth-1:0] reqPc;
	logic busy;
	logic granted;
	logic drop;
	logic canIssue;
	logic ifHold;
	logic useWord;

	assign canIssue = !loadEn && !stopFetch;
	assign ifHold = dStall || hazStall;
	assign iReq = busy;
	assign iAddr = reqPc;
	// no usable word this cycle
	assign iStall = !(iDone && !drop);
	assign useWord = !iStall && !brTaken && !ifHold;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			reqPc <= '0;
			busy <= 1'b0;
			granted <= 1'b0;
			drop <= 1'b0;
			ifValid <= 1'b0;
		end else begin
			if (brTaken) begin
				pc <= brTarget;
			end else if (useWord) begin
				pc <= pc + 1'b1;
			end
			if (busy) begin
				if (iGrant) begin
					granted <= 1'b1;
				end
				if (iDone) begin
					busy <= 1'b0;
					granted <= 1'b0;
					drop <= 1'b0;
				end else if (brTaken) begin
					// redirect mid-access makes the returning word stale
					drop <= 1'b1;
				end
			end else if (canIssue && !brTaken) begin
				busy <= 1'b1;
				reqPc <= pc;
			end
			if (!ifHold) begin
				ifValid <= !iStall && !brTaken;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (useWord) begin
			ifInstr <= memRdata;
			ifPc <= reqPc;
		end
	end

	// done only ever answers a granted request
	doneAfterGrant: assert property (@(posedge clk) disable iff (!rstN)
		iDone |-> busy && (granted || iGrant));

	// the arbiter grants a waiting access only once
	grantOnce: assert property (@(posedge clk) disable iff (!rstN)
		iGrant |-> busy && !granted);

endmodule

/* verilog/procPkg.sv */
// word and register-select widths
// opcode and ALU function encodings
// instruction word with R-format and I-format views
package procPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;

	// halt sits at zero so an empty memory word stops the core
	typedef enum logic [3:0] {
		opHalt  = 4'h0,
		opNop   = 4'h1,
		opAlu   = 4'h2,
		opAddi  = 4'h3,
		opLoad  = 4'h4,
		opStore = 4'h5,
		opBeqz  = 4'h6
	} opcodeT;

	typedef enum logic [2:0] {
		fnAdd = 3'd0,
		fnSub = 3'd1,
		fnAnd = 3'd2,
		fnOr  = 3'd3,
		fnXor = 3'd4,
		fnSlt = 3'd5
	} functT;

	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [regAddrWidth-1:0] rd;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			functT funct;
		} rType;
		struct packed {
			opcodeT opcode;
			logic [regAddrWidth-1:0] rd;
			logic [regAddrWidth-1:0] rs;
			logic signed [5:0] imm;
		} iType;
	} instrT;

endpackage
